//--- run.sh
#!/bin/sh
# Verilator build and run of the floor logic testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module floor_logic_tb -f tb.f -o floor_logic_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/floor_logic_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" sim.log; then
    exit 0
fi
exit 1

//--- tb.f
verilog/elev_pkg.sv
verilog/request_capture.sv
verilog/request_stack.sv
verilog/car_control.sv
verilog/floor_logic_top.sv
tests/floor_logic_props.sv
tests/floor_logic_tb.sv

//--- tests/floor_logic_props.sv
// Floor logic assertions
`timescale 1ns/1ns

module floor_logic_props import elev_pkg::*; (
    input logic        clock,
    input logic        reset_n,
    input buttons_t    buttons,
    input car_status_t car,
    input lights_t     lights,
    input floor_t      floor_selector,
    input logic        direction_selector,
    input logic        activate_elevator,
    input logic        door_open_allowed,
    input logic        door_close_allowed
);

    localparam logic [MAX_FLOORS-1:0] FIRST_FLOOR = 1;

    int fail_count = 0;

    logic [MAX_FLOORS-1:0] here;
    logic [MAX_FLOORS-1:0] lit;
    logic [MAX_FLOORS-1:0] pressed;
    logic                  stopped;
    logic                  live;
    logic                  parked;
    logic                  fresh_press;
    floor_t                press_floor;

    assign here    = FIRST_FLOOR << car.floor;
    assign lit     = lights.panel | lights.call;
    assign pressed = buttons.panel | buttons.call;
    assign stopped = car.state < 6'd11;
    assign live    = buttons.power && !buttons.emergency;
    // Car waiting at a floor with power on and no emergency
    assign parked  = stopped && live;
    // One button of an unlit floor other than the car's own
    assign fresh_press = live && $onehot({buttons.panel, buttons.call})
        && ((pressed & (lit | here)) == '0);

    always_comb begin
        press_floor = '0;
        for (int i = 0; i < MAX_FLOORS; i++) begin
            if (pressed[i]) begin
                press_floor = floor_t'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Requests and dispatch
    ////////////////////////////////////////////////////////////

    a_reset: assert property (@(posedge clock) $rose(reset_n)
        |-> lit == '0 && !activate_elevator && floor_selector == car.floor)
    else begin
        $error("Fail lights %h activate_elevator %h after reset", lights, activate_elevator);
        fail_count++;
    end

    // New request lights its lamp and at a stop becomes the target
    a_press: assert property (@(posedge clock) disable iff (!reset_n)
        fresh_press |=> ({lights.panel, lights.call} & $past({buttons.panel, buttons.call})) != '0
        && (!$past(stopped) || !parked || car.floor != $past(car.floor)
            || (activate_elevator && floor_selector == $past(press_floor)
                && direction_selector == ($past(press_floor) > car.floor))))
    else begin
        $error("Fail lights %h floor_selector %h activate_elevator %h direction_selector %h",
            lights, floor_selector, activate_elevator, direction_selector);
        fail_count++;
    end

    a_own_floor: assert property (@(posedge clock) disable iff (!reset_n)
        lit == '0 && pressed == here && buttons.power |=> lit == '0 && !activate_elevator)
    else begin
        $error("Fail lights %h activate_elevator %h on own floor", lights, activate_elevator);
        fail_count++;
    end

    // Arrival drops the floor and hands over to the newest pending one
    a_arrival: assert property (@(posedge clock) disable iff (!reset_n)
        parked && floor_selector == car.floor && lit[car.floor]
        |=> !lit[$past(car.floor)] && (lit == '0 || !parked || car.floor != $past(car.floor)
            || (activate_elevator && lit[floor_selector])))
    else begin
        $error("Fail lights %h floor_selector %h after arrival", lights, floor_selector);
        fail_count++;
    end

    ////////////////////////////////////////////////////////////
    // Emergency, power and doors
    ////////////////////////////////////////////////////////////

    a_emergency: assert property (@(posedge clock) disable iff (!reset_n)
        buttons.emergency |-> floor_selector == FLOOR_EMERGENCY && !activate_elevator)
    else begin
        $error("Fail floor_selector %h activate_elevator %h", floor_selector, activate_elevator);
        fail_count++;
    end

    a_flush: assert property (@(posedge clock) disable iff (!reset_n) !live |=> lit == '0)
    else begin
        $error("Fail lights %h expected 0", lights);
        fail_count++;
    end

    a_doors: assert property (@(posedge clock) disable iff (!reset_n)
        door_open_allowed == (stopped && buttons.power && buttons.door_open)
        && door_close_allowed == (stopped && buttons.power && buttons.door_close))
    else begin
        $error("Fail door_open_allowed %h door_close_allowed %h",
            door_open_allowed, door_close_allowed);
        fail_count++;
    end

endmodule

bind floor_logic_top floor_logic_props props (.*);

//--- tests/floor_logic_tb.sv
// Elevator floor logic testbench
`timescale 1ns/1ns

module floor_logic_tb import elev_pkg::*; ();

    // Every sequence together stays well under 200 cycles
    localparam int MAX_CYCLES = 2000;

    logic        clock = 1'b0;
    logic        reset_n;
    buttons_t    buttons;
    car_status_t car;
    lights_t     lights;
    floor_t      floor_selector;
    logic        direction_selector;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;
    int          cycles = 0;
    floor_t      first_floor;
    floor_t      second_floor;

    floor_logic_top #(.NUM_FLOORS(MAX_FLOORS)) UUT (.*);

    always #5 clock = ~clock;

    task automatic finish_run(input logic timeout);
        $display("Assertion failures: %0d  Timeouts: %0d", UUT.props.fail_count, timeout);
        if (timeout || UUT.props.fail_count != 0) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
        $finish;
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            finish_run(1'b1);
        end
    end

    // Advance to just after a rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clock);
        #1;
    endtask

    function automatic floor_t pick_floor(input floor_t avoid_a, input floor_t avoid_b);
        floor_t f;
        do begin
            f = floor_t'($urandom % MAX_FLOORS);
        end while (f == avoid_a || f == avoid_b);
        return f;
    endfunction

    task automatic press(input floor_t f, input logic on_panel);
        if (on_panel) begin
            buttons.panel[f] = 1'b1;
        end else begin
            buttons.call[f] = 1'b1;
        end
        step(1);
        buttons.panel = '0;
        buttons.call  = '0;
    endtask

    // Car FSM stand-in that dwells, travels one segment and stops at the target
    task automatic serve_next();
        floor_t target;
        while (!activate_elevator) begin
            step(1);
        end
        step(2);
        target        = floor_selector;
        car.direction = direction_selector;
        car.state     = direction_selector ? 6'd11 + car_state_t'(car.floor)
                                           : 6'd20 + car_state_t'(car.floor);
        buttons.door_open  = 1'b1;
        buttons.door_close = 1'b1;
        step(3);
        buttons.door_open  = 1'b0;
        buttons.door_close = 1'b0;
        car.floor = target;
        car.state = car_state_t'(target);
        step(1);
    endtask

    initial begin
        void'($urandom(6238));
        reset_n       = 1'b0;
        buttons       = '0;
        buttons.power = 1'b1;
        car           = '0;
        // A press held through reset leaves every lamp dark
        buttons.panel[3] = 1'b1;
        repeat (2) @(posedge clock);
        #1 reset_n = 1'b1;
        buttons.panel = '0;
        step(2);

        // Two requests in successive cycles with the newest served first
        first_floor  = pick_floor(car.floor, car.floor);
        second_floor = pick_floor(car.floor, first_floor);
        press(first_floor, 1'b1);
        press(second_floor, 1'b0);
        serve_next();
        serve_next();

        // Own floor and door buttons at a stop
        press(car.floor, 1'b1);
        press(car.floor, 1'b0);
        buttons.door_open = 1'b1;
        step(1);
        buttons.door_open  = 1'b0;
        buttons.door_close = 1'b1;
        step(1);
        buttons.door_close = 1'b0;

        // Request below the car is dispatched downward
        press(floor_t'(0), 1'b1);

        // Emergency then power loss with a request pending
        press(pick_floor(car.floor, car.floor), 1'b0);
        buttons.emergency = 1'b1;
        step(2);
        buttons.emergency = 1'b0;
        press(pick_floor(car.floor, car.floor), 1'b1);
        buttons.power = 1'b0;
        step(1);
        buttons.power = 1'b1;
        step(3);
        finish_run(1'b0);
    end

endmodule

//--- verilog/car_control.sv
// Dispatch and door permission
`timescale 1ns/1ns

module car_control import elev_pkg::*; (
    input  buttons_t    buttons,
    input  car_status_t car,
    input  floor_t      top_floor,
    input  logic        empty,
    output logic        flush,
    output logic        pop,
    output floor_t      floor_selector,
    output logic        direction_selector,
    output logic        activate_elevator,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    logic at_stop;
    logic powered_stop;
    logic serving;
    logic at_target;

    assign at_stop      = is_stop_state(car.state);
    assign powered_stop = at_stop && buttons.power;

    // Held high for as long as power is off or emergency is pressed
    assign flush = !buttons.power || buttons.emergency;

    // Stack top only counts while the car is parked and healthy
    assign serving   = !flush && at_stop && !empty;
    assign at_target = (top_floor == car.floor);

    // Arrival, drops the served entry and its lamps at the next edge
    assign pop = serving && at_target;

    ////////////////////////////////////////////////////////////
    // Target dispatch
    ////////////////////////////////////////////////////////////

    always_comb begin
        floor_selector     = car.floor;
        direction_selector = car.direction;
        activate_elevator  = 1'b0;
        if (buttons.emergency) begin
            floor_selector = FLOOR_EMERGENCY;
        end else if (serving) begin
            floor_selector     = top_floor;
            direction_selector = (top_floor > car.floor);
            activate_elevator  = !at_target;
        end
    end

    ////////////////////////////////////////////////////////////
    // Doors
    ////////////////////////////////////////////////////////////

    // Door buttons pass through only when parked with power on
    assign door_open_allowed  = powered_stop && buttons.door_open;
    assign door_close_allowed = powered_stop && buttons.door_close;

endmodule

//--- verilog/elev_pkg.sv
// Elevator floor logic types
package elev_pkg;

    ////////////////////////////////////////////////////////////
    // Floors
    ////////////////////////////////////////////////////////////

    // Number of served floors, sets the width of every light vector
    localparam int MAX_FLOORS = 11;

    // Floor number, 0 is the ground floor
    typedef logic [3:0] floor_t;

    // Selector value driven while the emergency button is held
    localparam floor_t FLOOR_EMERGENCY = 4'd15;

    ////////////////////////////////////////////////////////////
    // Car FSM state codes
    ////////////////////////////////////////////////////////////

    // 0..10 stop at a floor, 11..20 up segments,
    // 21..30 down segments, 31 emergency
    typedef logic [5:0] car_state_t;

    // First code that is not a stop state
    localparam car_state_t STATE_FIRST_UP = 6'd11;

    typedef struct packed {
        floor_t     floor;
        car_state_t state;
        logic       direction;  // 1 when travelling up
    } car_status_t;

    typedef struct packed {
        logic [MAX_FLOORS-1:0] panel;
        logic [MAX_FLOORS-1:0] call;
        logic                  door_open;
        logic                  door_close;
        logic                  emergency;
        logic                  power;
    } buttons_t;

    typedef struct packed {
        logic [MAX_FLOORS-1:0] call;
        logic [MAX_FLOORS-1:0] panel;
    } lights_t;

    // Stop states sit below the first travel segment
    function automatic logic is_stop_state(input car_state_t state);
        return state < STATE_FIRST_UP;
    endfunction

endpackage

//--- verilog/floor_logic_top.sv
// Elevator floor logic top level
`timescale 1ns/1ns

module floor_logic_top import elev_pkg::*; #(
    parameter int NUM_FLOORS = MAX_FLOORS
) (
    input  logic        clock,
    input  logic        reset_n,
    input  buttons_t    buttons,
    input  car_status_t car,
    output lights_t     lights,
    output floor_t      floor_selector,
    output logic        direction_selector,
    output logic        activate_elevator,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    logic   flush;
    logic   pop;
    logic   push;
    floor_t push_floor;
    floor_t top_floor;
    logic   empty;

    // Button priority and lamps
    request_capture #(
        .NUM_FLOORS (NUM_FLOORS)
    ) u_capture (
        .clock         (clock),
        .reset_n       (reset_n),
        .panel         (buttons.panel),
        .call          (buttons.call),
        .current_floor (car.floor),
        .flush         (flush),
        .pop           (pop),
        .push          (push),
        .push_floor    (push_floor),
        .lights        (lights)
    );

    // LIFO of pending floors
    request_stack #(
        .NUM_FLOORS (NUM_FLOORS)
    ) u_stack (
        .clock      (clock),
        .reset_n    (reset_n),
        .push       (push),
        .push_floor (push_floor),
        .pop        (pop),
        .flush      (flush),
        .top_floor  (top_floor),
        .empty      (empty)
    );

    car_control u_control (
        .buttons            (buttons),
        .car                (car),
        .top_floor          (top_floor),
        .empty              (empty),
        .flush              (flush),
        .pop                (pop),
        .floor_selector     (floor_selector),
        .direction_selector (direction_selector),
        .activate_elevator  (activate_elevator),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

//--- verilog/request_capture.sv
// Floor request capture
`timescale 1ns/1ns

module request_capture import elev_pkg::*; #(
    parameter int NUM_FLOORS = MAX_FLOORS
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic [MAX_FLOORS-1:0] panel,
    input  logic [MAX_FLOORS-1:0] call,
    input  floor_t                current_floor,
    input  logic                  flush,
    input  logic                  pop,
    output logic                  push,
    output floor_t                push_floor,
    output lights_t               lights
);

    localparam logic [MAX_FLOORS-1:0] ONE_HOT_0 = 1;

    logic [MAX_FLOORS-1:0] floor_valid;
    logic [MAX_FLOORS-1:0] cur_mask;
    logic [MAX_FLOORS-1:0] lit;
    logic [MAX_FLOORS-1:0] panel_press;
    logic [MAX_FLOORS-1:0] call_press;
    logic [MAX_FLOORS-1:0] panel_new;
    logic [MAX_FLOORS-1:0] call_new;
    logic [MAX_FLOORS-1:0] sel_mask;
    logic [MAX_FLOORS-1:0] panel_set;
    logic [MAX_FLOORS-1:0] call_set;
    logic [MAX_FLOORS-1:0] clear_mask;
    logic                  sel_found;
    logic                  sel_panel;
    floor_t                sel_floor;

    ////////////////////////////////////////////////////////////
    // Press qualification
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < MAX_FLOORS; i++) begin
            floor_valid[i] = (i < NUM_FLOORS);
        end
    end

    // Presses for the floor the car is at are dropped
    assign cur_mask    = ONE_HOT_0 << current_floor;
    assign lit         = lights.panel | lights.call;
    assign panel_press = panel & floor_valid & ~cur_mask;
    assign call_press  = call & floor_valid & ~cur_mask;

    // Only a floor with both lamps dark is a new request
    assign panel_new = panel_press & ~lit;
    assign call_new  = call_press & ~lit;

    // Lowest floor wins, panel group ahead of call group
    always_comb begin
        sel_found = 1'b0;
        sel_panel = 1'b0;
        sel_floor = '0;
        for (int i = MAX_FLOORS - 1; i >= 0; i--) begin
            if (call_new[i]) begin
                sel_found = 1'b1;
                sel_floor = floor_t'(i);
            end
        end
        for (int i = MAX_FLOORS - 1; i >= 0; i--) begin
            if (panel_new[i]) begin
                sel_found = 1'b1;
                sel_panel = 1'b1;
                sel_floor = floor_t'(i);
            end
        end
    end

    assign push       = sel_found && !flush;
    assign push_floor = sel_floor;
    assign sel_mask   = push ? (ONE_HOT_0 << sel_floor) : '0;

    // A lit floor pressed again just turns on the lamp of that group
    assign panel_set  = (panel_press & lit) | (sel_panel ? sel_mask : '0);
    assign call_set   = (call_press & lit) | (sel_panel ? '0 : sel_mask);
    assign clear_mask = pop ? cur_mask : '0;

    ////////////////////////////////////////////////////////////
    // Request lamps
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else if (flush) begin
            lights <= '0;
        end else begin
            lights.panel <= (lights.panel | panel_set) & ~clear_mask;
            lights.call  <= (lights.call | call_set) & ~clear_mask;
        end
    end

endmodule

//--- verilog/request_stack.sv
// Pending floor stack
`timescale 1ns/1ns

module request_stack import elev_pkg::*; #(
    parameter int NUM_FLOORS = MAX_FLOORS
) (
    input  logic   clock,
    input  logic   reset_n,
    input  logic   push,
    input  floor_t push_floor,
    input  logic   pop,
    input  logic   flush,
    output floor_t top_floor,
    output logic   empty
);

    localparam int IDX_W = $clog2(NUM_FLOORS);
    // Extra bit lets the pointer reach NUM_FLOORS
    localparam int PTR_W = IDX_W + 1;

    floor_t             entries [NUM_FLOORS];
    logic [PTR_W-1:0]   ptr;
    logic [PTR_W-1:0]   ptr_dec;
    logic [IDX_W-1:0]   top_idx;
    logic [IDX_W-1:0]   wr_idx;
    logic               pop_ok;

    assign empty   = (ptr == '0);
    assign pop_ok  = pop && !empty;
    assign ptr_dec = ptr - 1'b1;
    assign top_idx = ptr_dec[IDX_W-1:0];

    // Push with pop overwrites the current top in place
    assign wr_idx = pop_ok ? top_idx : ptr[IDX_W-1:0];

    assign top_floor = empty ? floor_t'(0) : entries[top_idx];

    ////////////////////////////////////////////////////////////
    // Pointer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ptr <= '0;
        end else if (flush) begin
            ptr <= '0;
        end else if (push && !pop_ok) begin
            ptr <= ptr + 1'b1;
        end else if (pop_ok && !push) begin
            ptr <= ptr_dec;
        end
    end

    ////////////////////////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (push && !flush) begin
            entries[wr_idx] <= push_floor;
        end
    end

endmodule
